/* filelist.f */
src/sr_conv_pkg.sv
src/coeff_bank.sv
src/conv_engine.sv
src/pixel_finish.sv
src/sr_conv_top.sv
tests/sr_conv_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= sr_conv_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TEST OK" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/sr_conv_tb.sv */
module sr_conv_tb;
    import sr_conv_pkg::*;

    localparam int clk_half      = 20;
    localparam int reset_cycles  = 5;
    localparam int start_to_done = 82;
    localparam int done_limit    = 200;
    localparam int idle_window   = 90;

    localparam int identity_pixels = 20;
    localparam int random_pixels   = 200;
    localparam int random_groups   = 10;
    localparam int timing_pixels   = 5;
    localparam int ignore_pixels   = 5;
    localparam int reload_rounds   = 5;
    localparam int total_pixels    = identity_pixels + random_pixels + timing_pixels
                                     + ignore_pixels + 2 * reload_rounds;
    // About 100 cycles per pixel covers loads and quiet checks
    localparam int watchdog_cycles = total_pixels * 100 + 10000;

    logic         clk;
    logic         rst_n;
    logic         coeff_load;
    coeff_write_t coeff_wr;
    logic         start;
    window_t      window;
    logic         busy;
    rgb_t         pixel_out;
    logic         pixel_done;

    logic [31:0] lcg_state;
    coeff_t      model_coeff [num_coeffs];
    int          error_count;
    int          tests_passed;
    int          tests_failed;
    int          test_index;

    sr_conv_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .coeff_load (coeff_load),
        .coeff_wr   (coeff_wr),
        .start      (start),
        .window     (window),
        .busy       (busy),
        .pixel_out  (pixel_out),
        .pixel_done (pixel_done)
    );

    always #(clk_half) clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // High bits of the LCG are the better ones
    function automatic logic [7:0] random_byte();
        logic [31:0] r;
        r = next_random();
        return r[31:24];
    endfunction

    function automatic window_t random_window();
        window_t w;
        for (int k = 0; k < kernel_taps; k++) begin
            for (int c = 0; c < num_channels; c++) begin
                w.tap[k].ch[c] = random_byte();
            end
        end
        return w;
    endfunction

    // Reference result from the testbench copy of the coefficients
    function automatic rgb_t model_pixel(input window_t w);
        rgb_t px;
        int   sum;
        int   value;
        for (int o = 0; o < num_channels; o++) begin
            sum = 0;
            for (int i = 0; i < num_channels; i++) begin
                for (int k = 0; k < kernel_taps; k++) begin
                    sum += int'(w.tap[k].ch[i])
                           * int'(model_coeff[(o * num_channels + i) * kernel_taps + k]);
                end
            end
            value = (sum + int'(model_coeff[num_weights + o]) * (1 << output_shift))
                    >>> output_shift;
            if (value < 0) begin
                px.ch[o] = 8'd0;
            end else if (value > 255) begin
                px.ch[o] = 8'd255;
            end else begin
                px.ch[o] = value[7:0];
            end
        end
        return px;
    endfunction

    task automatic check_pixel(input string name, input rgb_t got, input rgb_t expected);
        if (got !== expected) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("FAIL t=%0t %s got %b expected %b", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic load_coeffs();
        for (int a = 0; a < num_coeffs; a++) begin
            @(posedge clk);
            coeff_load    <= 1'b1;
            coeff_wr.addr <= coeff_addr_t'(a);
            coeff_wr.data <= model_coeff[a];
        end
        @(posedge clk);
        coeff_load <= 1'b0;
    endtask

    // Weight 64 on the centre tap of the same channel
    task automatic set_identity();
        for (int a = 0; a < num_coeffs; a++) begin
            model_coeff[a] = '0;
        end
        for (int c = 0; c < num_channels; c++) begin
            model_coeff[(c * num_channels + c) * kernel_taps + 4] = 8'sd64;
        end
        load_coeffs();
    endtask

    // Larger shift gives smaller weights, so fewer clamped channels
    task automatic set_random(input int shift);
        coeff_t w;
        for (int a = 0; a < num_coeffs; a++) begin
            w = random_byte();
            if (a < num_weights) begin
                model_coeff[a] = w >>> shift;
            end else begin
                model_coeff[a] = w;
            end
        end
        load_coeffs();
    endtask

    task automatic run_pixel(input window_t w, input logic second_start, output rgb_t got);
        int cycles;
        bit seen_done;
        @(posedge clk);
        start  <= 1'b1;
        window <= w;
        @(posedge clk);
        start     <= 1'b0;
        cycles    = 0;
        seen_done = 1'b0;
        while (!seen_done && cycles < done_limit) begin
            @(negedge clk);
            check_flag("busy", busy, (cycles <= start_to_done - 2));
            if (pixel_done) begin
                seen_done = 1'b1;
            end else begin
                @(posedge clk);
                cycles++;
                // Extra start and a new window in the middle of the run
                if (second_start && cycles == 5) begin
                    start  <= 1'b1;
                    window <= random_window();
                end
                if (second_start && cycles == 6) begin
                    start <= 1'b0;
                end
            end
        end
        if (!seen_done) begin
            $display("No pixel_done within %0d cycles of start at t=%0t", done_limit, $time);
            error_count++;
        end else begin
            check_count("start_to_done", cycles, start_to_done);
        end
        got = pixel_out;
    endtask

    task automatic expect_quiet(input int num_cycles);
        for (int n = 0; n < num_cycles; n++) begin
            @(negedge clk);
            check_flag("pixel_done", pixel_done, 1'b0);
            check_flag("busy", busy, 1'b0);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        int new_errors;
        new_errors = error_count - errors_before;
        test_index++;
        if (new_errors == 0) begin
            tests_passed++;
            $display("Test %0d %s: passed", test_index, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", test_index, name, new_errors);
        end
    endtask

    initial begin
        rgb_t    got;
        rgb_t    expected;
        window_t w;
        int      errors_before;

        clk          = 1'b0;
        rst_n        = 1'b0;
        coeff_load   = 1'b0;
        coeff_wr     = '0;
        start        = 1'b0;
        window       = '0;
        lcg_state    = 32'hd85a4574;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_index   = 0;

        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        errors_before = error_count;
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("pixel_done", pixel_done, 1'b0);
        check_pixel("pixel_out", pixel_out, '0);
        report_test("reset values", errors_before);

        errors_before = error_count;
        set_identity();
        for (int p = 0; p < identity_pixels; p++) begin
            w = random_window();
            run_pixel(w, 1'b0, got);
            check_pixel("pixel_out", got, w.tap[4]);
        end
        report_test("identity kernel", errors_before);

        errors_before = error_count;
        for (int g = 0; g < random_groups; g++) begin
            set_random(g % 5);
            for (int p = 0; p < random_pixels / random_groups; p++) begin
                w        = random_window();
                expected = model_pixel(w);
                run_pixel(w, 1'b0, got);
                check_pixel("pixel_out", got, expected);
            end
        end
        report_test("random coefficients", errors_before);

        errors_before = error_count;
        for (int p = 0; p < timing_pixels; p++) begin
            w        = random_window();
            expected = model_pixel(w);
            run_pixel(w, 1'b0, got);
            check_pixel("pixel_out", got, expected);
            expect_quiet(idle_window);
        end
        report_test("start to done timing", errors_before);

        errors_before = error_count;
        for (int p = 0; p < ignore_pixels; p++) begin
            w        = random_window();
            expected = model_pixel(w);
            run_pixel(w, 1'b1, got);
            check_pixel("pixel_out", got, expected);
            expect_quiet(idle_window);
        end
        report_test("start while busy", errors_before);

        errors_before = error_count;
        for (int r = 0; r < reload_rounds; r++) begin
            w = random_window();
            set_random(2);
            expected = model_pixel(w);
            run_pixel(w, 1'b0, got);
            check_pixel("pixel_out", got, expected);
            set_random(3);
            expected = model_pixel(w);
            run_pixel(w, 1'b0, got);
            check_pixel("pixel_out", got, expected);
        end
        report_test("coefficient reload", errors_before);

        $display("Tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: simulation did not finish within %0d cycles", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* src/sr_conv_top.sv */
module sr_conv_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      coeff_load,
    input  sr_conv_pkg::coeff_write_t coeff_wr,
    input  logic                      start,
    input  sr_conv_pkg::window_t      window,
    output logic                      busy,
    output sr_conv_pkg::rgb_t         pixel_out,
    output logic                      pixel_done
);
    import sr_conv_pkg::*;

    coeff_addr_t  weight_addr;
    coeff_t       weight;
    partial_sum_t partial;
    channel_t     bias_channel;
    coeff_t       bias;

    // Weights and biases, loaded from outside
    coeff_bank i_coeff_bank (
        .clk          (clk),
        .rst_n        (rst_n),
        .coeff_load   (coeff_load),
        .coeff_wr     (coeff_wr),
        .weight_addr  (weight_addr),
        .weight       (weight),
        .bias_channel (bias_channel),
        .bias         (bias)
    );

    // One MAC per clock over all 81 weights
    conv_engine i_conv_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .window      (window),
        .weight_addr (weight_addr),
        .weight      (weight),
        .partial     (partial),
        .busy        (busy)
    );

    // Bias, scale, clamp and pack
    pixel_finish i_pixel_finish (
        .clk          (clk),
        .rst_n        (rst_n),
        .partial      (partial),
        .bias_channel (bias_channel),
        .bias         (bias),
        .pixel_out    (pixel_out),
        .pixel_done   (pixel_done)
    );

endmodule

/* src/pixel_finish.sv */
module pixel_finish (
    input  logic                      clk,
    input  logic                      rst_n,
    input  sr_conv_pkg::partial_sum_t partial,
    output sr_conv_pkg::channel_t     bias_channel,
    input  sr_conv_pkg::coeff_t       bias,
    output sr_conv_pkg::rgb_t         pixel_out,
    output logic                      pixel_done
);
    import sr_conv_pkg::*;

    localparam acc_t sample_max = 255;

    acc_t    bias_scaled;
    acc_t    biased;
    acc_t    scaled;
    sample_t result;

    assign bias_channel = partial.channel;

    // Bias is on the same scale as the weights
    assign bias_scaled = acc_t'(bias) <<< output_shift;
    assign biased      = partial.sum + bias_scaled;
    assign scaled      = biased >>> output_shift;

    // ReLU, then saturate to one byte
    always_comb begin
        if (scaled < 0) begin
            result = '0;
        end else if (scaled > sample_max) begin
            result = '1;
        end else begin
            result = sample_t'(scaled);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_out  <= '0;
            pixel_done <= 1'b0;
        end else begin
            pixel_done <= 1'b0;
            if (partial.valid) begin
                pixel_out.ch[partial.channel] <= result;
                // Last channel completes the pixel
                if (partial.channel == channel_t'(num_channels - 1)) begin
                    pixel_done <= 1'b1;
                end
            end
        end
    end

endmodule

/* src/conv_engine.sv */
module conv_engine (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  sr_conv_pkg::window_t      window,
    output sr_conv_pkg::coeff_addr_t  weight_addr,
    input  sr_conv_pkg::coeff_t       weight,
    output sr_conv_pkg::partial_sum_t partial,
    output logic                      busy
);
    import sr_conv_pkg::*;

    engine_state_t state;
    window_t       win_q;

    // Step counters, tap fastest and out-channel slowest
    channel_t   out_ch;
    channel_t   in_ch;
    logic [3:0] tap;

    acc_t    acc;
    acc_t    acc_next;
    acc_t    product;
    sample_t sample;

    logic last_tap;
    logic last_in;
    logic last_out;

    assign last_tap = (tap == 4'(kernel_taps - 1));
    assign last_in  = (in_ch == channel_t'(num_channels - 1));
    assign last_out = (out_ch == channel_t'(num_channels - 1));

    assign weight_addr = coeff_addr_t'((out_ch * num_channels + in_ch) * kernel_taps + tap);

    assign sample = win_q.tap[tap].ch[in_ch];

    // Unsigned sample times signed weight
    assign product  = $signed({1'b0, sample}) * weight;
    assign acc_next = acc + product;

    assign busy = (state == run);

    // Window is held for the whole run
    always_ff @(posedge clk) begin
        if (state == idle && start) begin
            win_q <= window;
        end
    end

    // Counters and accumulator are back at zero whenever the FSM is idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= idle;
            out_ch  <= '0;
            in_ch   <= '0;
            tap     <= '0;
            acc     <= '0;
            partial <= '0;
        end else begin
            partial.valid <= 1'b0;

            unique case (state)
                idle: begin
                    if (start) begin
                        state <= run;
                    end
                end

                run: begin
                    acc <= acc_next;

                    if (last_tap) begin
                        tap <= '0;
                        if (last_in) begin
                            in_ch <= '0;

                            // 27th product of this out-channel
                            partial.valid   <= 1'b1;
                            partial.channel <= out_ch;
                            partial.sum     <= acc_next;
                            acc             <= '0;

                            if (last_out) begin
                                out_ch <= '0;
                                state  <= idle;
                            end else begin
                                out_ch <= out_ch + 1'b1;
                            end
                        end else begin
                            in_ch <= in_ch + 1'b1;
                        end
                    end else begin
                        tap <= tap + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

/* src/coeff_bank.sv */
module coeff_bank (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      coeff_load,
    input  sr_conv_pkg::coeff_write_t coeff_wr,
    input  sr_conv_pkg::coeff_addr_t  weight_addr,
    output sr_conv_pkg::coeff_t       weight,
    input  sr_conv_pkg::channel_t     bias_channel,
    output sr_conv_pkg::coeff_t       bias
);
    import sr_conv_pkg::*;

    coeff_t      coeff_mem [num_coeffs];
    coeff_addr_t bias_addr;

    // Out-of-range writes are dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_coeffs; i++) begin
                coeff_mem[i] <= '0;
            end
        end else if (coeff_load && (coeff_wr.addr < coeff_addr_t'(num_coeffs))) begin
            coeff_mem[coeff_wr.addr] <= coeff_wr.data;
        end
    end

    // Biases follow the weight block
    assign bias_addr = coeff_addr_t'(num_weights) + coeff_addr_t'(bias_channel);

    assign weight = coeff_mem[weight_addr];
    assign bias   = coeff_mem[bias_addr];

endmodule

/* src/sr_conv_pkg.sv */
package sr_conv_pkg;

    // Geometry of one 3x3 RGB convolution stage
    localparam int kernel_taps      = 9;
    localparam int num_channels     = 3;
    localparam int macs_per_channel = num_channels * kernel_taps;
    localparam int num_weights      = num_channels * macs_per_channel;
    localparam int num_coeffs       = num_weights + num_channels;

    // Weights are fixed point, 64 is 1.0
    localparam int output_shift = 6;

    // Unsigned colour sample
    typedef logic [7:0] sample_t;

    // Signed weight or bias
    typedef logic signed [7:0] coeff_t;

    // Weight (o, i, k) at (o*3+i)*9+k, bias of o at 81+o
    typedef logic [6:0] coeff_addr_t;

    typedef logic [1:0] channel_t;

    // Holds 27 products plus the scaled bias
    typedef logic signed [21:0] acc_t;

    // Channel 0 sits in the low byte
    typedef struct packed {
        sample_t [num_channels-1:0] ch;
    } rgb_t;

    // Tap k is row*3+column, tap 0 lowest
    typedef struct packed {
        rgb_t [kernel_taps-1:0] tap;
    } window_t;

    typedef struct packed {
        coeff_addr_t addr;
        coeff_t      data;
    } coeff_write_t;

    // One finished channel sum from the engine
    typedef struct packed {
        logic     valid;
        channel_t channel;
        acc_t     sum;
    } partial_sum_t;

    typedef enum logic {
        idle,
        run
    } engine_state_t;

endpackage
